/* bicubic_ctrl.sv */
`timescale 1ns/1ps

module bicubic_ctrl
    import bicubic_pkg::*;
#(
    parameter int CREDITS      = 4,
    parameter int MULT_LATENCY = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  logic         credit_return,
    input  phase_t       in_phase,
    output weight_code_t w0,
    output weight_code_t w1,
    output weight_code_t w2,
    output weight_code_t w3,
    output logic         ena,
    output logic         out_valid
);

    localparam int CW    = $clog2(CREDITS + 1);
    localparam int DEPTH = MULT_LATENCY + 3;  // Multiplier, two adder stages, normalizer.

    logic [CW-1:0]    credit_cnt;
    logic [DEPTH-1:0] vld;
    logic             accept;

    // Each accepted input already owns a sink slot, so nothing downstream stalls.
    assign in_ready = (credit_cnt != '0);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CW'(CREDITS);
        end else begin
            case ({accept, credit_return})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + 1'b1;
                end
                default: begin
                    credit_cnt <= credit_cnt;  // Both or neither.
                end
            endcase
        end
    end

    // Valid bits shadow the data through every datapath register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[DEPTH-2:0], accept};
        end
    end

    // The last bit is the output register itself, which need not advance.
    assign ena       = accept | (|vld[DEPTH-2:0]);
    assign out_valid = vld[DEPTH-1];

    assign w0 = PHASE_WEIGHTS[in_phase][0];
    assign w1 = PHASE_WEIGHTS[in_phase][1];
    assign w2 = PHASE_WEIGHTS[in_phase][2];
    assign w3 = PHASE_WEIGHTS[in_phase][3];

endmodule

/* bicubic_mult_stage2.sv */
`timescale 1ns/1ps

module bicubic_mult_stage2
    import bicubic_pkg::*;
#(
    parameter int PRODUCT_WIDTH = bicubic_pkg::PRODUCT_WIDTH,
    parameter int MULT_LATENCY  = 2
) (
    input  logic                            clk,
    input  logic                            ena,
    input  weight_code_t                    weight,
    input  logic signed [PRODUCT_WIDTH-9:0] pixel,
    output logic signed [PRODUCT_WIDTH-1:0] product
);

    logic signed [COEFF_WIDTH-1:0]   coeff;
    logic signed [PRODUCT_WIDTH-1:0] product_data;
    logic signed [PRODUCT_WIDTH-1:0] chain [MULT_LATENCY];

    assign coeff = COEFF_TABLE[weight];

    // Evaluated at PRODUCT_WIDTH bits, so the upper bits of the full product drop.
    assign product_data = pixel * coeff;

    always_ff @(posedge clk) begin
        if (ena) begin
            chain[0] <= product_data;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign product = chain[MULT_LATENCY-1];  // Models a pipelined multiplier.

endmodule

/* bicubic_normalize.sv */
`timescale 1ns/1ps

module bicubic_normalize
    import bicubic_pkg::*;
#(
    parameter int PRODUCT_WIDTH = bicubic_pkg::PRODUCT_WIDTH
) (
    input  logic                            clk,
    input  logic                            ena,
    input  logic signed [PRODUCT_WIDTH+1:0] sum,
    output pixel_t                          pixel
);

    localparam int NW = PRODUCT_WIDTH + 3;
    localparam logic signed [NW-1:0] ROUND   = 1 <<< (NORM_SHIFT - 1);
    localparam logic signed [NW-1:0] PIX_MAX = (1 <<< PIXEL_WIDTH) - 1;

    logic signed [NW-1:0] rounded;
    logic signed [NW-1:0] shifted;
    pixel_t               clamped;
    pixel_t               pixel_q;

    assign rounded = sum + ROUND;  // One extra bit so the rounding add cannot wrap.
    assign shifted = rounded >>> NORM_SHIFT;

    always_comb begin
        if (shifted < 0) begin
            clamped = '0;
        end else if (shifted > PIX_MAX) begin
            clamped = '1;
        end else begin
            clamped = shifted[PIXEL_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            pixel_q <= clamped;
        end
    end

    assign pixel = pixel_q;

endmodule

/* bicubic_pkg.sv */
package bicubic_pkg;

    localparam int PRODUCT_WIDTH = 32;
    localparam int SAMPLE_WIDTH  = PRODUCT_WIDTH - 8;  // Signed intermediate sample.
    localparam int SUM_WIDTH     = PRODUCT_WIDTH + 2;  // Room for four products.
    localparam int PIXEL_WIDTH   = 10;
    localparam int NORM_SHIFT    = 11;
    localparam int COEFF_WIDTH   = 12;

    typedef logic [2:0] weight_code_t;
    typedef logic [1:0] phase_t;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // Coefficients are scaled by 2048 to match the shift by NORM_SHIFT.
    localparam logic signed [COEFF_WIDTH-1:0] COEFF_TABLE [8] = '{
        -12'sd21,
        -12'sd135,
        -12'sd147,
        -12'sd225,
        12'sd235,
        12'sd873,
        12'sd1535,
        12'sd1981
    };

    // Weight codes for source rows 0 to 3, one line per phase.
    localparam weight_code_t PHASE_WEIGHTS [4][4] = '{
        '{3'd0, 3'd7, 3'd4, 3'd0},
        '{3'd1, 3'd6, 3'd5, 3'd2},
        '{3'd2, 3'd5, 3'd6, 3'd1},
        '{3'd3, 3'd5, 3'd5, 3'd3}
    };

endpackage

/* bicubic_sum_tree.sv */
`timescale 1ns/1ps

module bicubic_sum_tree #(
    parameter int PRODUCT_WIDTH = bicubic_pkg::PRODUCT_WIDTH
) (
    input  logic                            clk,
    input  logic                            ena,
    input  logic signed [PRODUCT_WIDTH-1:0] p0,
    input  logic signed [PRODUCT_WIDTH-1:0] p1,
    input  logic signed [PRODUCT_WIDTH-1:0] p2,
    input  logic signed [PRODUCT_WIDTH-1:0] p3,
    output logic signed [PRODUCT_WIDTH+1:0] sum
);

    logic signed [PRODUCT_WIDTH:0]   sum01;
    logic signed [PRODUCT_WIDTH:0]   sum23;
    logic signed [PRODUCT_WIDTH+1:0] sum_q;

    // Stage one, pairwise sums with one guard bit.
    always_ff @(posedge clk) begin
        if (ena) begin
            sum01 <= p0 + p1;
            sum23 <= p2 + p3;
        end
    end

    // Stage two, total of both pairs.
    always_ff @(posedge clk) begin
        if (ena) begin
            sum_q <= sum01 + sum23;
        end
    end

    assign sum = sum_q;

endmodule

/* bicubic_v_top.sv */
`timescale 1ns/1ps

module bicubic_v_top
    import bicubic_pkg::*;
#(
    parameter int PRODUCT_WIDTH = bicubic_pkg::PRODUCT_WIDTH,
    parameter int MULT_LATENCY  = 2,
    parameter int CREDITS       = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  phase_t                          in_phase,
    input  logic signed [PRODUCT_WIDTH-9:0] in_s0,
    input  logic signed [PRODUCT_WIDTH-9:0] in_s1,
    input  logic signed [PRODUCT_WIDTH-9:0] in_s2,
    input  logic signed [PRODUCT_WIDTH-9:0] in_s3,
    output logic                            out_valid,
    output pixel_t                          out_pixel,
    input  logic                            credit_return
);

    weight_code_t                    w0;
    weight_code_t                    w1;
    weight_code_t                    w2;
    weight_code_t                    w3;
    logic                            ena;
    logic signed [PRODUCT_WIDTH-1:0] p0;
    logic signed [PRODUCT_WIDTH-1:0] p1;
    logic signed [PRODUCT_WIDTH-1:0] p2;
    logic signed [PRODUCT_WIDTH-1:0] p3;
    logic signed [PRODUCT_WIDTH+1:0] sum;

    bicubic_ctrl #(
        .CREDITS      (CREDITS),
        .MULT_LATENCY (MULT_LATENCY)
    ) i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .in_phase      (in_phase),
        .w0            (w0),
        .w1            (w1),
        .w2            (w2),
        .w3            (w3),
        .ena           (ena),
        .out_valid     (out_valid)
    );

    // One tap per source row.
    bicubic_mult_stage2 #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH),
        .MULT_LATENCY  (MULT_LATENCY)
    ) i_mult0 (.clk(clk), .ena(ena), .weight(w0), .pixel(in_s0), .product(p0));

    bicubic_mult_stage2 #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH),
        .MULT_LATENCY  (MULT_LATENCY)
    ) i_mult1 (.clk(clk), .ena(ena), .weight(w1), .pixel(in_s1), .product(p1));

    bicubic_mult_stage2 #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH),
        .MULT_LATENCY  (MULT_LATENCY)
    ) i_mult2 (.clk(clk), .ena(ena), .weight(w2), .pixel(in_s2), .product(p2));

    bicubic_mult_stage2 #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH),
        .MULT_LATENCY  (MULT_LATENCY)
    ) i_mult3 (.clk(clk), .ena(ena), .weight(w3), .pixel(in_s3), .product(p3));

    bicubic_sum_tree #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH)
    ) i_sum_tree (
        .clk (clk),
        .ena (ena),
        .p0  (p0),
        .p1  (p1),
        .p2  (p2),
        .p3  (p3),
        .sum (sum)
    );

    bicubic_normalize #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH)
    ) i_normalize (
        .clk   (clk),
        .ena   (ena),
        .sum   (sum),
        .pixel (out_pixel)
    );

endmodule

/* tb_bicubic_v.sv */
`timescale 1ns/1ps

module tb_bicubic_v
    import bicubic_pkg::*;
;

    localparam int MULT_LATENCY = 2;
    localparam int CREDITS      = 4;
    localparam int CW           = $clog2(CREDITS + 1);
    localparam int CLK_PERIOD   = 4;
    localparam int N_FIXED      = 9;
    localparam int N_SAT        = 4;
    localparam int N_STREAM     = 40;
    localparam int N_BP         = 24;
    localparam int N_RAND       = 300;
    localparam int TOTAL_ITEMS  = N_FIXED + N_SAT + N_STREAM + N_BP + N_RAND;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_ITEMS + 200;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [CW-1:0] credit_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    phase_t  in_phase;
    sample_t in_s0;
    sample_t in_s1;
    sample_t in_s2;
    sample_t in_s3;
    logic    out_valid;
    pixel_t  out_pixel;
    logic    credit_return;

    pixel_t      exp_q [$];
    int          tb_credits;
    credit_t     held;           // Pixels the sink holds and has not yet released.
    int          release_wait;
    int          delay_min;
    int          delay_max;
    int unsigned seed_val;

    bicubic_v_top #(
        .PRODUCT_WIDTH (PRODUCT_WIDTH),
        .MULT_LATENCY  (MULT_LATENCY),
        .CREDITS       (CREDITS)
    ) i_bicubic_v_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_phase      (in_phase),
        .in_s0         (in_s0),
        .in_s1         (in_s1),
        .in_s2         (in_s2),
        .in_s3         (in_s3),
        .out_valid     (out_valid),
        .out_pixel     (out_pixel),
        .credit_return (credit_return)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run("Output pixel differs from the reference.");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run("Handshake signal has the wrong level.");
        end
    endtask

    task automatic check_credit(input credit_t count);
        if (count >= CREDITS) begin
            abort_run($sformatf("Sink overflow: a pixel arrived while the sink held %0d pixels.",
                                count));
        end
    endtask

    // Weighted sum of the four rows, rounded, shifted and clamped to the pixel range.
    function automatic pixel_t ref_pixel(input phase_t ph, input sample_t a, input sample_t b,
                                         input sample_t c, input sample_t d);
        sample_t                         s [4];
        longint                          acc;
        longint                          prod;
        logic signed [PRODUCT_WIDTH-1:0] trunc;
        pixel_t                          result;
        s[0] = a;
        s[1] = b;
        s[2] = c;
        s[3] = d;
        acc  = 0;
        for (int k = 0; k < 4; k++) begin
            prod  = longint'(s[k]) * longint'(COEFF_TABLE[PHASE_WEIGHTS[ph][k]]);
            trunc = prod[PRODUCT_WIDTH-1:0];  // A product keeps only its low bits.
            acc   = acc + longint'(trunc);
        end
        acc = (acc + (longint'(1) <<< (NORM_SHIFT - 1))) >>> NORM_SHIFT;
        if (acc < 0) begin
            result = '0;
        end else if (acc > (longint'(1) <<< PIXEL_WIDTH) - 1) begin
            result = '1;
        end else begin
            result = pixel_t'(acc);
        end
        return result;
    endfunction

    function automatic sample_t rand_sample();
        int v;
        v = int'($urandom_range(0, 2 * (1 << 18))) - (1 << 18);
        return sample_t'(v);
    endfunction

    // Called at 1 ns after a rising edge; returns at the same point after the transfer.
    task automatic send_item(input phase_t ph, input sample_t a, input sample_t b,
                             input sample_t c, input sample_t d);
        logic took;
        exp_q.push_back(ref_pixel(ph, a, b, c, d));
        in_valid = 1'b1;
        in_phase = ph;
        in_s0    = a;
        in_s1    = b;
        in_s2    = c;
        in_s3    = d;
        took     = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Credit tracking follows the values that the next rising edge will see.
    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("in_ready", in_ready, tb_credits != 0);
            tb_credits = tb_credits + int'(credit_return) - int'(in_valid && in_ready);
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            check_credit(held);
            held = held + 1'b1;
            if (exp_q.size() == 0) begin
                abort_run("An output pixel arrived with no expected result left.");
            end
            check_pixel("out_pixel", out_pixel, exp_q.pop_front());
        end
    end

    // Sink releases one slot per pulse, after a random number of cycles.
    always @(posedge clk) begin
        #1;
        credit_return = 1'b0;
        if (rst_n && held != 0) begin
            if (release_wait == 0) begin
                credit_return = 1'b1;
                held          = held - 1'b1;
                release_wait  = $urandom_range(delay_min, delay_max);
            end else begin
                release_wait = release_wait - 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        seed_val      = $urandom(32'h48b2c092);
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_phase      = '0;
        in_s0         = '0;
        in_s1         = '0;
        in_s2         = '0;
        in_s3         = '0;
        credit_return = 1'b0;
        tb_credits    = CREDITS;
        held          = '0;
        release_wait  = 0;
        delay_min     = 0;
        delay_max     = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);
        @(posedge clk);
        #1;

        for (int ph = 0; ph < 4; ph++) begin
            send_item(phase_t'(ph), 24'sd120000, 24'sd90000, -24'sd50000, 24'sd200000);
            send_item(phase_t'(ph), -24'sd40000, 24'sd262000, 24'sd1000, -24'sd131072);
        end
        send_item(2'd0, 24'sh7fffff, 24'sh7fffff, 24'sh400000, 24'sh800000);  // Wraps.

        send_item(2'd0, 24'sd0, 24'sd1000000, 24'sd1000000, 24'sd0);
        send_item(2'd3, 24'sd1000000, 24'sd0, 24'sd0, 24'sd1000000);
        send_item(2'd1, 24'sd0, -24'sd1000000, -24'sd1000000, 24'sd0);
        send_item(2'd2, 24'sd900000, 24'sd900000, 24'sd900000, 24'sd900000);

        for (int i = 0; i < N_STREAM; i++) begin
            send_item(phase_t'(i % 4), rand_sample(), rand_sample(), rand_sample(),
                      rand_sample());
        end

        delay_min = 10;  // Long holds starve the credits.
        delay_max = 30;
        for (int i = 0; i < N_BP; i++) begin
            send_item(phase_t'($urandom_range(0, 3)), rand_sample(), rand_sample(),
                      rand_sample(), rand_sample());
        end

        delay_min = 0;
        delay_max = 6;
        for (int i = 0; i < N_RAND; i++) begin
            send_item(phase_t'($urandom_range(0, 3)), rand_sample(), rand_sample(),
                      rand_sample(), rand_sample());
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles($urandom_range(1, 3));
            end
        end

        wait (exp_q.size() == 0);
        idle_cycles(MULT_LATENCY + 5);  // Any duplicate would show up here.
        $display("Test passed");
        $finish;
    end

endmodule

/* verilog.f */
bicubic_pkg.sv
bicubic_mult_stage2.sv
bicubic_sum_tree.sv
bicubic_normalize.sv
bicubic_ctrl.sv
bicubic_v_top.sv
tb_bicubic_v.sv
